// File: csr_file.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_commit_buffer.sv
verilog/csr_regs.sv
verilog/csr_trap_logic.sv
verilog/csr_atomic_check.sv
verilog/csr_file_top.sv
verification/csr_file_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the CSR file testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f csr_file.f --top-module csr_file_tb \
  -o csr_file_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/csr_file_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended early"; exit 1; }
exit 0

// File: verification/csr_file_tb.sv
// CSR file testbench with stimulus table, reference model, value checks and watchdog
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_file_tb
  import csr_pkg::*;
();

  // operation bits that can be combined within one table row
  localparam logic [7:0] OP_NONE   = 8'h00;
  localparam logic [7:0] OP_WR     = 8'h01;
  localparam logic [7:0] OP_COMMIT = 8'h02;
  localparam logic [7:0] OP_FLUSH  = 8'h04;
  localparam logic [7:0] OP_RD     = 8'h08;
  localparam logic [7:0] OP_EXC    = 8'h10;
  localparam logic [7:0] OP_SRET   = 8'h20;
  localparam logic [7:0] OP_FF     = 8'h40;
  localparam logic [7:0] OP_RETIRE = 8'h80;

  // register slots of the reference model
  localparam logic [3:0] R_FFLAGS   = 4'd0;
  localparam logic [3:0] R_FRM      = 4'd1;
  localparam logic [3:0] R_SUP0     = 4'd2;
  localparam logic [3:0] R_SUP1     = 4'd3;
  localparam logic [3:0] R_EPC      = 4'd4;
  localparam logic [3:0] R_BADVADDR = 4'd5;
  localparam logic [3:0] R_COUNT    = 4'd6;
  localparam logic [3:0] R_EVEC     = 4'd7;
  localparam logic [3:0] R_CAUSE    = 4'd8;
  localparam logic [3:0] R_STATUS   = 4'd9;
  localparam logic [3:0] R_NONE     = 4'd15;

  // one cycle of stimulus plus what the outputs must show during it
  typedef struct packed {
    logic [7:0]  kind;
    csr_addr_t   addr;
    csr_word_t   data;
    csr_word_t   ld;
    csr_word_t   st;
    logic [4:0]  cause;
    logic [2:0]  cnt;
    csr_addr_t   rd_addr;
    csr_word_t   exp_rd;
    logic        exp_vio;
    csr_word_t   exp_frm;
    csr_word_t   exp_status;
    csr_word_t   exp_evec;
    csr_word_t   exp_epc;
  } row_t;

  logic clk, reset, flush_i, reg_wr_en_i, commit_reg_i, reg_rd_en_i;
  logic exception_i, sret_i, atomic_rd_vio_o;
  csr_addr_t reg_wr_addr_i, reg_rd_addr_i;
  csr_word_t reg_wr_data_i, exception_pc_i, st_commit_addr_i, ld_commit_addr_i, fflags_i;
  logic [`COMMIT_CNT_WIDTH-1:0] total_commit_i;
  logic [`CAUSE_WIDTH-1:0]      exception_cause_i;
  csr_word_t reg_rd_data_o, csr_epc_o, csr_evec_o, csr_status_o, csr_frm_o;

  row_t        rows[$];
  logic        table_ready;
  logic [31:0] lfsr;
  csr_addr_t   csr_addrs [0:9];

  // reference model state
  csr_word_t   m_regs [0:9];
  logic        m_pend_valid;
  csr_addr_t   m_pend_addr;
  csr_word_t   m_pend_data;
  logic        m_chk_valid;
  csr_addr_t   m_chk_addr;
  csr_word_t   m_chk_data;

  csr_file_top uut (
    .clk (clk), .reset (reset), .flush_i (flush_i),
    .reg_wr_addr_i (reg_wr_addr_i), .reg_wr_data_i (reg_wr_data_i),
    .reg_wr_en_i (reg_wr_en_i), .commit_reg_i (commit_reg_i),
    .reg_rd_addr_i (reg_rd_addr_i), .reg_rd_en_i (reg_rd_en_i),
    .total_commit_i (total_commit_i), .exception_i (exception_i),
    .exception_pc_i (exception_pc_i), .exception_cause_i (exception_cause_i),
    .st_commit_addr_i (st_commit_addr_i), .ld_commit_addr_i (ld_commit_addr_i),
    .sret_i (sret_i), .fflags_i (fflags_i),
    .reg_rd_data_o (reg_rd_data_o), .csr_epc_o (csr_epc_o), .csr_evec_o (csr_evec_o),
    .csr_status_o (csr_status_o), .csr_frm_o (csr_frm_o),
    .atomic_rd_vio_o (atomic_rd_vio_o)
  );

  always #4 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic csr_word_t rand_bits(input int nbits);
    csr_word_t v;
    logic      fb;
    v = '0;
    for (int i = 0; i < nbits; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic has_op(input logic [7:0] kind, input logic [7:0] op);
    return (kind & op) != 8'h00;
  endfunction

  // CSR address map of the core
  function automatic logic [3:0] reg_index(input csr_addr_t addr);
    logic [3:0] idx;
    case (addr)
      `CSR_ADDR_FFLAGS:   idx = R_FFLAGS;
      `CSR_ADDR_FRM:      idx = R_FRM;
      `CSR_ADDR_SUP0:     idx = R_SUP0;
      `CSR_ADDR_SUP1:     idx = R_SUP1;
      `CSR_ADDR_EPC:      idx = R_EPC;
      `CSR_ADDR_BADVADDR: idx = R_BADVADDR;
      `CSR_ADDR_COUNT:    idx = R_COUNT;
      `CSR_ADDR_EVEC:     idx = R_EVEC;
      `CSR_ADDR_CAUSE:    idx = R_CAUSE;
      `CSR_ADDR_STATUS:   idx = R_STATUS;
      default:            idx = R_NONE;
    endcase
    return idx;
  endfunction

  // unknown addresses read zero
  function automatic csr_word_t model_read(input csr_addr_t addr);
    logic [3:0] idx;
    idx = reg_index(addr);
    if (idx == R_NONE)
      return '0;
    return m_regs[idx];
  endfunction

  function automatic csr_word_t write_mask(input logic [3:0] idx);
    csr_word_t m;
    case (idx)
      R_FFLAGS: m = `CSR_FFLAGS_MASK;
      R_FRM:    m = `CSR_FRM_MASK;
      R_STATUS: m = `CSR_STATUS_MASK;
      default:  m = '1;
    endcase
    return m;
  endfunction

  task automatic check_value(input string name, input csr_word_t actual,
                             input csr_word_t expected);
    if (actual !== expected)
    begin
      $display("error: time %0t signal %s actual %h expected %h",
               $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // records expectations from the current model state and then steps it one edge
  task automatic add_row(input logic [7:0] kind, input csr_addr_t addr, input csr_word_t data,
                         input logic [4:0] cause, input logic [2:0] cnt,
                         input csr_addr_t rd_addr);
    row_t        r;
    logic [3:0]  c_idx;
    logic        do_commit;
    csr_status_u st;
    r.kind = kind;
    r.addr = addr;
    r.data = data;
    r.cause = cause;
    r.cnt = cnt;
    r.rd_addr = rd_addr;
    r.ld = rand_bits(64);
    r.st = rand_bits(64);
    r.exp_rd = model_read(rd_addr);
    r.exp_vio = m_chk_valid && (model_read(m_chk_addr) != m_chk_data);
    r.exp_frm = m_regs[R_FRM];
    r.exp_status = m_regs[R_STATUS];
    r.exp_evec = m_regs[R_EVEC];
    r.exp_epc = m_regs[R_EPC];
    rows.push_back(r);
    // commit uses the write pending before this edge
    do_commit = has_op(kind, OP_COMMIT) && m_pend_valid;
    c_idx = reg_index(m_pend_addr);
    // the read checkpoint sees the pre-edge value
    if (has_op(kind, OP_RD))
    begin
      m_chk_valid = 1'b1;
      m_chk_addr = rd_addr;
      m_chk_data = model_read(rd_addr);
    end
    else if (has_op(kind, OP_FLUSH) || has_op(kind, OP_COMMIT))
      m_chk_valid = 1'b0;
    if (has_op(kind, OP_FF))
      m_regs[R_FFLAGS] = m_regs[R_FFLAGS] | (data & `CSR_FFLAGS_MASK);
    // retired instructions plus the excepting one
    m_regs[R_COUNT] = m_regs[R_COUNT] + csr_word_t'(cnt) + csr_word_t'(has_op(kind, OP_EXC));
    if (has_op(kind, OP_EXC))
    begin
      m_regs[R_EPC] = data;
      m_regs[R_CAUSE] = csr_word_t'(cause);
      if (cause == `CAUSE_MISALIGNED_FETCH || cause == `CAUSE_FAULT_FETCH)
        m_regs[R_BADVADDR] = data;
      else if (cause == `CAUSE_MISALIGNED_LOAD || cause == `CAUSE_FAULT_LOAD)
        m_regs[R_BADVADDR] = r.ld;
      else if (cause == `CAUSE_MISALIGNED_STORE || cause == `CAUSE_FAULT_STORE)
        m_regs[R_BADVADDR] = r.st;
    end
    if (has_op(kind, OP_SRET))
    begin
      st.raw = m_regs[R_STATUS];
      st.fields.s = st.fields.ps;
      st.fields.ei = st.fields.pei;
      m_regs[R_STATUS] = st.raw;
    end
    // software write beats the hardware update
    if (do_commit && c_idx != R_NONE)
      m_regs[c_idx] = m_pend_data & write_mask(c_idx);
    if (has_op(kind, OP_WR))
    begin
      m_pend_valid = 1'b1;
      m_pend_addr = addr;
      m_pend_data = data;
    end
    else if (has_op(kind, OP_FLUSH))
      m_pend_valid = 1'b0;
  endtask

  task automatic build_table();
    logic [3:0] k;
    logic [4:0] c;
    csr_word_t  rnd;
    csr_addrs = '{`CSR_ADDR_FFLAGS, `CSR_ADDR_FRM, `CSR_ADDR_SUP0, `CSR_ADDR_SUP1,
                  `CSR_ADDR_EPC, `CSR_ADDR_BADVADDR, `CSR_ADDR_COUNT, `CSR_ADDR_EVEC,
                  `CSR_ADDR_CAUSE, `CSR_ADDR_STATUS};
    m_regs = '{default: '0};
    m_regs[R_STATUS] = `CSR_STATUS_RESET;
    m_pend_valid = 1'b0;
    m_chk_valid = 1'b0;
    // reset values, then one unmapped address
    for (k = 4'd0; k < 4'd10; k = k + 4'd1)
      add_row(OP_NONE, '0, '0, '0, 3'd0, csr_addrs[k]);
    add_row(OP_NONE, '0, '0, '0, 3'd0, 12'h7ff);
    // write stays hidden until commit
    for (k = 4'd0; k < 4'd10; k = k + 4'd1)
    begin
      add_row(OP_WR, csr_addrs[k], rand_bits(64), '0, 3'd0, csr_addrs[k]);
      add_row(OP_NONE, '0, '0, '0, 3'd0, csr_addrs[k]);
      add_row(OP_COMMIT, '0, '0, '0, 3'd0, csr_addrs[k]);
      add_row(OP_NONE, '0, '0, '0, 3'd0, csr_addrs[k]);
    end
    // flushed write never lands
    add_row(OP_WR, `CSR_ADDR_SUP1, rand_bits(64), '0, 3'd0, `CSR_ADDR_SUP1);
    add_row(OP_FLUSH, '0, '0, '0, 3'd0, `CSR_ADDR_SUP1);
    add_row(OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_SUP1);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_SUP1);
    // every cause code 0..7 since the badvaddr source depends on it
    for (c = 5'd0; c < 5'd8; c = c + 5'd1)
    begin
      rnd = rand_bits(3);
      add_row(OP_EXC, '0, rand_bits(64), c, rnd[2:0], `CSR_ADDR_COUNT);
      add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_BADVADDR);
      add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_CAUSE);
    end
    for (k = 4'd0; k < 4'd4; k = k + 4'd1)
    begin
      rnd = rand_bits(3);
      add_row(OP_RETIRE, '0, '0, '0, rnd[2:0], `CSR_ADDR_COUNT);
    end
    // fflags accumulation, then a committed write replaces it
    for (k = 4'd0; k < 4'd4; k = k + 4'd1)
      add_row(OP_FF, '0, rand_bits(64), '0, 3'd0, `CSR_ADDR_FFLAGS);
    add_row(OP_WR, `CSR_ADDR_FFLAGS, rand_bits(64), '0, 3'd0, `CSR_ADDR_FFLAGS);
    add_row(OP_COMMIT | OP_FF, '0, rand_bits(64), '0, 3'd0, `CSR_ADDR_FFLAGS);
    add_row(OP_FF, '0, rand_bits(64), '0, 3'd0, `CSR_ADDR_FFLAGS);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_FFLAGS);
    // PS and PEI set, S and EI clear before sret
    rnd = rand_bits(64);
    add_row(OP_WR, `CSR_ADDR_STATUS, (rnd & ~64'hf) | 64'ha, '0, 3'd0, `CSR_ADDR_STATUS);
    add_row(OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_STATUS);
    add_row(OP_SRET, '0, '0, '0, 3'd0, `CSR_ADDR_STATUS);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_STATUS);
    // read of sup0 overtaken by a committed write and cleared by commit
    add_row(OP_WR, `CSR_ADDR_SUP0, rand_bits(64), '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_RD | OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    // same again but cleared by flush
    add_row(OP_WR, `CSR_ADDR_SUP0, rand_bits(64), '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_RD | OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_FLUSH, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_SUP0);
    // count moved by retirement after its read
    add_row(OP_RD, '0, '0, '0, 3'd0, `CSR_ADDR_COUNT);
    add_row(OP_RETIRE, '0, '0, '0, 3'd5, `CSR_ADDR_COUNT);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_COUNT);
    add_row(OP_COMMIT, '0, '0, '0, 3'd0, `CSR_ADDR_COUNT);
    add_row(OP_NONE, '0, '0, '0, 3'd0, `CSR_ADDR_COUNT);
  endtask

  task automatic drive_row(input row_t r);
    reg_wr_en_i       = has_op(r.kind, OP_WR);
    commit_reg_i      = has_op(r.kind, OP_COMMIT);
    flush_i           = has_op(r.kind, OP_FLUSH);
    reg_rd_en_i       = has_op(r.kind, OP_RD);
    exception_i       = has_op(r.kind, OP_EXC);
    sret_i            = has_op(r.kind, OP_SRET);
    reg_wr_addr_i     = r.addr;
    reg_wr_data_i     = r.data;
    reg_rd_addr_i     = r.rd_addr;
    exception_pc_i    = r.data;
    exception_cause_i = r.cause;
    ld_commit_addr_i  = r.ld;
    st_commit_addr_i  = r.st;
    total_commit_i    = r.cnt;
    fflags_i          = has_op(r.kind, OP_FF) ? r.data : '0;
  endtask

  initial
  begin
    row_t cur;
    clk = 1'b0;
    reset = 1'b1;
    table_ready = 1'b0;
    lfsr = 32'h69f2_e7af;
    drive_row('0);
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // drive on the falling edge and check once outputs have settled
    for (int i = 0; i < rows.size(); i++)
    begin
      cur = rows[i];
      drive_row(cur);
      #1;
      check_value("reg_rd_data_o", reg_rd_data_o, cur.exp_rd);
      check_value("atomic_rd_vio_o", csr_word_t'(atomic_rd_vio_o), csr_word_t'(cur.exp_vio));
      check_value("csr_frm_o", csr_frm_o, cur.exp_frm);
      check_value("csr_status_o", csr_status_o, cur.exp_status);
      check_value("csr_evec_o", csr_evec_o, cur.exp_evec);
      check_value("csr_epc_o", csr_epc_o, cur.exp_epc);
      @(negedge clk);
    end
    drive_row('0);
    $display("Done: no errors");
    $finish;
  end

  // table length plus reset plus slack at 8 ns per cycle
  initial
  begin
    wait (table_ready);
    #((rows.size() + 16 + 20) * 8);
    $display("timeout: the stimulus table did not complete in the expected time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verilog/csr_atomic_check.sv
// CSR read checkpoint and atomicity-violation flag
`timescale 1ns/1ns

module csr_atomic_check
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      flush_i,
  input  logic      commit_reg_i,
  input  logic      rd_en_i,
  input  csr_addr_t rd_addr_i,
  input  csr_word_t rd_data_i,
  input  csr_word_t chk_data_i,
  output csr_addr_t chk_addr_o,
  output logic      atomic_rd_vio_o
);

  logic      chk_valid_q;
  csr_addr_t chk_addr_q;
  csr_word_t chk_data_q;

  // address and value seen by the CSR read
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_i;
    end
  end

  // checkpoint lives until the CSR instruction commits or is squashed
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      chk_valid_q <= 1'b0;
    else if (rd_en_i)
      chk_valid_q <= 1'b1;
    else if (flush_i || commit_reg_i)
      chk_valid_q <= 1'b0;
  end

  // live register looked up through the check port
  assign chk_addr_o      = chk_addr_q;
  assign atomic_rd_vio_o = chk_valid_q && (chk_data_i != chk_data_q);

  // a retired checkpoint raises no violation
  a_vio_needs_chkpt: assert property (@(posedge clk) disable iff (reset)
    ((flush_i || commit_reg_i) && !rd_en_i) |=> !atomic_rd_vio_o);

endmodule

// File: verilog/csr_commit_buffer.sv
// pending CSR write buffer, released on commit and dropped on flush
`timescale 1ns/1ns

module csr_commit_buffer
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      flush_i,
  input  logic      reg_wr_en_i,
  input  csr_addr_t reg_wr_addr_i,
  input  csr_word_t reg_wr_data_i,
  input  logic      commit_reg_i,
  output logic      commit_wr_en_o,
  output csr_addr_t commit_wr_addr_o,
  output csr_word_t commit_wr_data_o
);

  logic      pend_valid_q;
  csr_addr_t pend_addr_q;
  csr_word_t pend_data_q;

  // payload of the write captured at execute
  always_ff @(posedge clk)
  begin
    if (reg_wr_en_i)
    begin
      pend_addr_q <= reg_wr_addr_i;
      pend_data_q <= reg_wr_data_i;
    end
  end

  // a new write beats a flush in the same cycle
  // commit leaves the flag set, only flush clears it
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pend_valid_q <= 1'b0;
    else if (reg_wr_en_i)
      pend_valid_q <= 1'b1;
    else if (flush_i)
      pend_valid_q <= 1'b0;
  end

  // register bank writes on this same edge
  assign commit_wr_en_o   = commit_reg_i & pend_valid_q;
  assign commit_wr_addr_o = pend_addr_q;
  assign commit_wr_data_o = pend_data_q;

  // a squashed write must never reach the bank
  a_no_commit_after_flush: assert property (@(posedge clk) disable iff (reset)
    (flush_i && !reg_wr_en_i) |=> !commit_wr_en_o);

endmodule

// File: verilog/csr_file_top.sv
// CSR file top level: commit buffer, register bank, trap logic and atomicity check
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_file_top
  import csr_pkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush_i,
  input  csr_addr_t                     reg_wr_addr_i,
  input  csr_word_t                     reg_wr_data_i,
  input  logic                          reg_wr_en_i,
  input  logic                          commit_reg_i,
  input  csr_addr_t                     reg_rd_addr_i,
  input  logic                          reg_rd_en_i,
  input  logic [`COMMIT_CNT_WIDTH-1:0]  total_commit_i,
  input  logic                          exception_i,
  input  csr_word_t                     exception_pc_i,
  input  logic [`CAUSE_WIDTH-1:0]       exception_cause_i,
  input  csr_word_t                     st_commit_addr_i,
  input  csr_word_t                     ld_commit_addr_i,
  input  logic                          sret_i,
  input  csr_word_t                     fflags_i,
  output csr_word_t                     reg_rd_data_o,
  output csr_word_t                     csr_epc_o,
  output csr_word_t                     csr_evec_o,
  output csr_word_t                     csr_status_o,
  output csr_word_t                     csr_frm_o,
  output logic                          atomic_rd_vio_o
);

  // committed write into the bank
  logic      commit_wr_en;
  csr_addr_t commit_wr_addr;
  csr_word_t commit_wr_data;

  // current trap-updated registers
  csr_word_t cause;
  csr_word_t badvaddr;
  csr_word_t count;

  // hardware next-state values
  csr_word_t epc_next;
  csr_word_t cause_next;
  csr_word_t badvaddr_next;
  csr_word_t count_next;
  csr_word_t status_next;

  // checkpoint port
  csr_addr_t chk_addr;
  csr_word_t chk_data;

  csr_commit_buffer u_commit_buffer (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush_i),
    .reg_wr_en_i      (reg_wr_en_i),
    .reg_wr_addr_i    (reg_wr_addr_i),
    .reg_wr_data_i    (reg_wr_data_i),
    .commit_reg_i     (commit_reg_i),
    .commit_wr_en_o   (commit_wr_en),
    .commit_wr_addr_o (commit_wr_addr),
    .commit_wr_data_o (commit_wr_data)
  );

  csr_regs u_regs (
    .clk              (clk),
    .reset            (reset),
    .commit_wr_en_i   (commit_wr_en),
    .commit_wr_addr_i (commit_wr_addr),
    .commit_wr_data_i (commit_wr_data),
    .fflags_i         (fflags_i),
    .epc_next_i       (epc_next),
    .cause_next_i     (cause_next),
    .badvaddr_next_i  (badvaddr_next),
    .count_next_i     (count_next),
    .status_next_i    (status_next),
    .rd_addr_i        (reg_rd_addr_i),
    .chk_addr_i       (chk_addr),
    .rd_data_o        (reg_rd_data_o),
    .chk_data_o       (chk_data),
    .epc_o            (csr_epc_o),
    .cause_o          (cause),
    .badvaddr_o       (badvaddr),
    .count_o          (count),
    .status_o         (csr_status_o),
    .evec_o           (csr_evec_o),
    .frm_o            (csr_frm_o)
  );

  csr_trap_logic u_trap_logic (
    .exception_i       (exception_i),
    .exception_pc_i    (exception_pc_i),
    .exception_cause_i (exception_cause_i),
    .ld_commit_addr_i  (ld_commit_addr_i),
    .st_commit_addr_i  (st_commit_addr_i),
    .total_commit_i    (total_commit_i),
    .sret_i            (sret_i),
    .epc_i             (csr_epc_o),
    .cause_i           (cause),
    .badvaddr_i        (badvaddr),
    .count_i           (count),
    .status_i          (csr_status_o),
    .epc_next_o        (epc_next),
    .cause_next_o      (cause_next),
    .badvaddr_next_o   (badvaddr_next),
    .count_next_o      (count_next),
    .status_next_o     (status_next)
  );

  csr_atomic_check u_atomic_check (
    .clk             (clk),
    .reset           (reset),
    .flush_i         (flush_i),
    .commit_reg_i    (commit_reg_i),
    .rd_en_i         (reg_rd_en_i),
    .rd_addr_i       (reg_rd_addr_i),
    .rd_data_i       (reg_rd_data_o),
    .chk_data_i      (chk_data),
    .chk_addr_o      (chk_addr),
    .atomic_rd_vio_o (atomic_rd_vio_o)
  );

endmodule

// File: verilog/csr_macros.svh
// width, address, mask, reset-value and cause-code constants for the CSR file
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// data word and address widths
`define CSR_WIDTH          64
`define CSR_ADDR_WIDTH     12
// committed-instruction count per cycle
`define COMMIT_CNT_WIDTH   3
`define CAUSE_WIDTH        5

// CSR address map
`define CSR_ADDR_FFLAGS    12'h001
`define CSR_ADDR_FRM       12'h002
`define CSR_ADDR_SUP0      12'h500
`define CSR_ADDR_SUP1      12'h501
`define CSR_ADDR_EPC       12'h502
`define CSR_ADDR_BADVADDR  12'h503
`define CSR_ADDR_COUNT     12'h506
`define CSR_ADDR_EVEC      12'h508
`define CSR_ADDR_CAUSE     12'h509
`define CSR_ADDR_STATUS    12'h50a

// writable bits per register
`define CSR_FFLAGS_MASK    64'h0000_0000_0000_001f
`define CSR_FRM_MASK       64'h0000_0000_0000_0007
// S..VM and IM only; EA, IP and unused bits stay zero
`define CSR_STATUS_MASK    64'h0000_0000_00ff_00ff
// S, EF, U64 and S64 set out of reset
`define CSR_STATUS_RESET   64'h0000_0000_0000_0071

// exception cause codes that carry a bad address
`define CAUSE_MISALIGNED_FETCH  5'd0
`define CAUSE_FAULT_FETCH       5'd1
`define CAUSE_MISALIGNED_LOAD   5'd4
`define CAUSE_MISALIGNED_STORE  5'd5
`define CAUSE_FAULT_LOAD        5'd6
`define CAUSE_FAULT_STORE       5'd7

`endif

// File: verilog/csr_pkg.sv
// CSR word, address and status register types
`include "csr_macros.svh"

package csr_pkg;

  // one CSR data word
  typedef logic [`CSR_WIDTH-1:0] csr_word_t;

  // one CSR address
  typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

  // status register fields, msb first
  typedef struct packed {
    logic [31:0] unused_hi;
    // interrupt pending, never set in this core
    logic [7:0]  ip;
    // interrupt mask
    logic [7:0]  im;
    logic [6:0]  unused_lo;
    logic        ea;
    logic        vm;
    logic        s64;
    logic        u64;
    logic        ef;
    // previous interrupt enable, restored by sret
    logic        pei;
    logic        ei;
    // previous supervisor mode, restored by sret
    logic        ps;
    logic        s;
  } csr_status_fields_t;

  // raw word for write/mask/read, fields for sret
  typedef union packed {
    csr_word_t          raw;
    csr_status_fields_t fields;
  } csr_status_u;

endpackage

// File: verilog/csr_regs.sv
// architectural CSR bank with masked write decode, read port and check port
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_regs
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      commit_wr_en_i,
  input  csr_addr_t commit_wr_addr_i,
  input  csr_word_t commit_wr_data_i,
  input  csr_word_t fflags_i,
  input  csr_word_t epc_next_i,
  input  csr_word_t cause_next_i,
  input  csr_word_t badvaddr_next_i,
  input  csr_word_t count_next_i,
  input  csr_word_t status_next_i,
  input  csr_addr_t rd_addr_i,
  input  csr_addr_t chk_addr_i,
  output csr_word_t rd_data_o,
  output csr_word_t chk_data_o,
  output csr_word_t epc_o,
  output csr_word_t cause_o,
  output csr_word_t badvaddr_o,
  output csr_word_t count_o,
  output csr_word_t status_o,
  output csr_word_t evec_o,
  output csr_word_t frm_o
);

  csr_word_t   fflags_q;
  csr_word_t   frm_q;
  csr_word_t   sup0_q;
  csr_word_t   sup1_q;
  csr_word_t   epc_q;
  csr_word_t   badvaddr_q;
  csr_word_t   count_q;
  csr_word_t   evec_q;
  csr_word_t   cause_q;
  csr_status_u status_q;

  // per-register write strobes
  logic wr_fflags, wr_frm, wr_sup0, wr_sup1, wr_epc;
  logic wr_badvaddr, wr_count, wr_evec, wr_cause, wr_status;

  // address decode of the committed write
  always_comb
  begin
    wr_fflags   = 1'b0;
    wr_frm      = 1'b0;
    wr_sup0     = 1'b0;
    wr_sup1     = 1'b0;
    wr_epc      = 1'b0;
    wr_badvaddr = 1'b0;
    wr_count    = 1'b0;
    wr_evec     = 1'b0;
    wr_cause    = 1'b0;
    wr_status   = 1'b0;
    if (commit_wr_en_i)
    begin
      case (commit_wr_addr_i)
        `CSR_ADDR_FFLAGS:   wr_fflags   = 1'b1;
        `CSR_ADDR_FRM:      wr_frm      = 1'b1;
        `CSR_ADDR_SUP0:     wr_sup0     = 1'b1;
        `CSR_ADDR_SUP1:     wr_sup1     = 1'b1;
        `CSR_ADDR_EPC:      wr_epc      = 1'b1;
        `CSR_ADDR_BADVADDR: wr_badvaddr = 1'b1;
        `CSR_ADDR_COUNT:    wr_count    = 1'b1;
        `CSR_ADDR_EVEC:     wr_evec     = 1'b1;
        `CSR_ADDR_CAUSE:    wr_cause    = 1'b1;
        `CSR_ADDR_STATUS:   wr_status   = 1'b1;
        default:            ;
      endcase
    end
  end

  // committed write wins over the hardware update
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fflags_q     <= '0;
      frm_q        <= '0;
      sup0_q       <= '0;
      sup1_q       <= '0;
      epc_q        <= '0;
      badvaddr_q   <= '0;
      count_q      <= '0;
      evec_q       <= '0;
      cause_q      <= '0;
      status_q.raw <= `CSR_STATUS_RESET;
    end
    else
    begin
      // retiring FP ops accumulate their flags
      fflags_q     <= wr_fflags ? (commit_wr_data_i & `CSR_FFLAGS_MASK)
                                : (fflags_q | (fflags_i & `CSR_FFLAGS_MASK));
      frm_q        <= wr_frm ? (commit_wr_data_i & `CSR_FRM_MASK) : frm_q;
      sup0_q       <= wr_sup0 ? commit_wr_data_i : sup0_q;
      sup1_q       <= wr_sup1 ? commit_wr_data_i : sup1_q;
      evec_q       <= wr_evec ? commit_wr_data_i : evec_q;
      // trap-updated registers
      epc_q        <= wr_epc ? commit_wr_data_i : epc_next_i;
      badvaddr_q   <= wr_badvaddr ? commit_wr_data_i : badvaddr_next_i;
      count_q      <= wr_count ? commit_wr_data_i : count_next_i;
      cause_q      <= wr_cause ? commit_wr_data_i : cause_next_i;
      status_q.raw <= wr_status ? (commit_wr_data_i & `CSR_STATUS_MASK) : status_next_i;
    end
  end

  // one decoder shared by the read and check ports
  function automatic csr_word_t csr_read(input csr_addr_t addr);
    csr_word_t data;
    case (addr)
      `CSR_ADDR_FFLAGS:   data = fflags_q;
      `CSR_ADDR_FRM:      data = frm_q;
      `CSR_ADDR_SUP0:     data = sup0_q;
      `CSR_ADDR_SUP1:     data = sup1_q;
      `CSR_ADDR_EPC:      data = epc_q;
      `CSR_ADDR_BADVADDR: data = badvaddr_q;
      `CSR_ADDR_COUNT:    data = count_q;
      `CSR_ADDR_EVEC:     data = evec_q;
      `CSR_ADDR_CAUSE:    data = cause_q;
      `CSR_ADDR_STATUS:   data = status_q.raw;
      // unmapped addresses read zero
      default:            data = '0;
    endcase
    return data;
  endfunction

  always_comb
  begin
    rd_data_o  = csr_read(rd_addr_i);
    chk_data_o = csr_read(chk_addr_i);
  end

  assign epc_o      = epc_q;
  assign cause_o    = cause_q;
  assign badvaddr_o = badvaddr_q;
  assign count_o    = count_q;
  assign status_o   = status_q.raw;
  assign evec_o     = evec_q;
  assign frm_o      = frm_q;

  // nothing sets interrupt pending, through writes or the sret path
  a_status_ip_zero: assert property (@(posedge clk) disable iff (reset)
    status_q.fields.ip == '0);

endmodule

// File: verilog/csr_trap_logic.sv
// next-state values for epc, cause, badvaddr, count and status
`timescale 1ns/1ns
`include "csr_macros.svh"

module csr_trap_logic
  import csr_pkg::*;
(
  input  logic                          exception_i,
  input  csr_word_t                     exception_pc_i,
  input  logic [`CAUSE_WIDTH-1:0]       exception_cause_i,
  input  csr_word_t                     ld_commit_addr_i,
  input  csr_word_t                     st_commit_addr_i,
  input  logic [`COMMIT_CNT_WIDTH-1:0]  total_commit_i,
  input  logic                          sret_i,
  input  csr_word_t                     epc_i,
  input  csr_word_t                     cause_i,
  input  csr_word_t                     badvaddr_i,
  input  csr_word_t                     count_i,
  input  csr_word_t                     status_i,
  output csr_word_t                     epc_next_o,
  output csr_word_t                     cause_next_o,
  output csr_word_t                     badvaddr_next_o,
  output csr_word_t                     count_next_o,
  output csr_word_t                     status_next_o
);

  csr_status_u status_cur;
  csr_status_u status_nxt;

  // exception records the faulting pc and zero-extended cause
  assign epc_next_o   = exception_i ? exception_pc_i : epc_i;
  assign cause_next_o = exception_i ? csr_word_t'(exception_cause_i) : cause_i;

  // retired count plus one for the excepting instruction
  assign count_next_o = count_i + csr_word_t'(total_commit_i) + csr_word_t'(exception_i);

  // bad address source picked by cause
  always_comb
  begin
    badvaddr_next_o = badvaddr_i;
    if (exception_i)
    begin
      case (exception_cause_i)
        `CAUSE_MISALIGNED_FETCH,
        `CAUSE_FAULT_FETCH:      badvaddr_next_o = exception_pc_i;
        `CAUSE_MISALIGNED_LOAD,
        `CAUSE_FAULT_LOAD:       badvaddr_next_o = ld_commit_addr_i;
        `CAUSE_MISALIGNED_STORE,
        `CAUSE_FAULT_STORE:      badvaddr_next_o = st_commit_addr_i;
        default:                 badvaddr_next_o = badvaddr_i;
      endcase
    end
  end

  // sret restores S from PS and EI from PEI
  always_comb
  begin
    status_cur.raw = status_i;
    status_nxt     = status_cur;
    if (sret_i)
    begin
      status_nxt.fields.s  = status_cur.fields.ps;
      status_nxt.fields.ei = status_cur.fields.pei;
    end
    status_next_o = status_nxt.raw;
  end

  // the retire stage never signals a trap and a return together
  always_comb
  begin
    a_no_exc_with_sret: assert #0 (!(exception_i && sret_i));
  end

endmodule
